//--- logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // rv64 byte address
  localparam int ADDR_W = 64;

  // one read beat from instruction memory
  localparam int DATA_W = 64;

  // base isa instruction, no compressed support
  localparam int INST_W = 32;

  // addi x0,x0,0
  localparam logic [INST_W-1:0] NOP_INST = 32'h0000_0013;

  // read response codes, axi encoding
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // payload of one memory word
  typedef logic [DATA_W-1:0] mem_word_t;

endpackage

`default_nettype wire

//--- logic/axi_rd_if.sv
`default_nettype none

interface axi_rd_if;

  // read address channel
  logic                        ar_valid;
  logic                        ar_ready;
  logic [fetch_pkg::ADDR_W-1:0] ar_addr;

  // read data channel, single beat per address
  logic                        r_valid;
  logic                        r_ready;
  fetch_pkg::mem_word_t        r_data;
  logic [1:0]                  r_resp;

  modport master (
    output ar_valid,
    output ar_addr,
    output r_ready,
    input  ar_ready,
    input  r_valid,
    input  r_data,
    input  r_resp
  );

  modport slave (
    input  ar_valid,
    input  ar_addr,
    input  r_ready,
    output ar_ready,
    output r_valid,
    output r_data,
    output r_resp
  );

endinterface

`default_nettype wire

//--- logic/pc_gen.sv
`default_nettype none

module pc_gen #(
  parameter logic [fetch_pkg::ADDR_W-1:0] RESET_PC = '0
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          redirect_i,
  input  wire [fetch_pkg::ADDR_W-1:0]  redirect_pc_i,
  input  wire                          stall_i,
  input  wire                          fetch_done_i,
  output logic                         fetch_req_o,
  output logic [fetch_pkg::ADDR_W-1:0] fetch_addr_o,
  output logic                         squash_o
);

  // sequential step, no prediction beyond pc+4
  localparam logic [fetch_pkg::ADDR_W-1:0] PC_STEP = 4;

  logic [fetch_pkg::ADDR_W-1:0] pc_q;
  logic [fetch_pkg::ADDR_W-1:0] redir_pc_q;
  logic                         outstanding_q;
  logic                         redir_pend_q;

  // new request only when bus side is free
  // a redirect this cycle moves pc first, so hold the request back
  assign fetch_req_o  = ~outstanding_q & ~stall_i & ~redirect_i;
  assign fetch_addr_o = pc_q;

  // redirect against a fetch on the bus kills that fetch
  assign squash_o     = redirect_i & outstanding_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q          <= RESET_PC;
      outstanding_q <= 1'b0;
      redir_pend_q  <= 1'b0;
    end else begin
      // one fetch in flight at most
      if (fetch_req_o) begin
        outstanding_q <= 1'b1;
      end else if (fetch_done_i) begin
        outstanding_q <= 1'b0;
      end

      if (redirect_i && (!outstanding_q || fetch_done_i)) begin
        // bus idle or finishing now, take target at once
        pc_q         <= redirect_pc_i;
        redir_pend_q <= 1'b0;
      end else if (redirect_i) begin
        // keep fetch address steady until the old beat returns
        redir_pend_q <= 1'b1;
      end else if (fetch_done_i) begin
        pc_q         <= redir_pend_q ? redir_pc_q : pc_q + PC_STEP;
        redir_pend_q <= 1'b0;
      end
    end
  end

  // parked redirect target, latest one wins
  always_ff @(posedge clk) begin
    if (redirect_i) begin
      redir_pc_q <= redirect_pc_i;
    end
  end

  // master latches the address, but it must not move under it
  a_addr_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (outstanding_q && !fetch_done_i) |=> $stable(fetch_addr_o)
  ) else $error("fetch address changed while a fetch was outstanding");

endmodule

`default_nettype wire

//--- logic/fetch_axi_master.sv
`default_nettype none

module fetch_axi_master (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          fetch_req_i,
  input  wire [fetch_pkg::ADDR_W-1:0]  fetch_addr_i,
  output logic                         fetch_done_o,
  output fetch_pkg::mem_word_t         rd_data_o,
  output logic [1:0]                   rd_resp_o,
  output logic [fetch_pkg::ADDR_W-1:0] rd_addr_o,
  axi_rd_if.master                     bus
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,
    S_DATA
  } state_t;

  state_t                       state_q;
  logic [fetch_pkg::ADDR_W-1:0] addr_q;
  fetch_pkg::mem_word_t         data_q;
  logic [1:0]                   resp_q;
  logic                         ar_hs;
  logic                         r_hs;

  // ar channel driven from the address state only
  assign bus.ar_valid = (state_q == S_ADDR);
  assign bus.ar_addr  = addr_q;

  // ready held through the whole data wait
  assign bus.r_ready  = (state_q == S_DATA);

  assign ar_hs = bus.ar_valid & bus.ar_ready;
  assign r_hs  = bus.r_valid & bus.r_ready;

  // completion in the beat acceptance cycle
  assign fetch_done_o = r_hs;

  // live beat on acceptance and last beat held afterwards
  assign rd_data_o = r_hs ? bus.r_data : data_q;
  assign rd_resp_o = r_hs ? bus.r_resp : resp_q;
  assign rd_addr_o = addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (fetch_req_i) begin
            state_q <= S_ADDR;
          end
        end
        S_ADDR: begin
          if (ar_hs) begin
            state_q <= S_DATA;
          end
        end
        S_DATA: begin
          if (r_hs) begin
            state_q <= S_IDLE;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // address captured once per request
  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && fetch_req_i) begin
      addr_q <= fetch_addr_i;
    end
  end

  // keep the accepted beat
  always_ff @(posedge clk) begin
    if (r_hs) begin
      data_q <= bus.r_data;
      resp_q <= bus.r_resp;
    end
  end

  // valid must wait for the slave
  a_ar_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (bus.ar_valid && !bus.ar_ready) |=> (bus.ar_valid && $stable(bus.ar_addr))
  ) else $error("ar_valid dropped or address moved before ar_ready");

  // a beat only comes back while one is awaited
  a_r_in_data: assert property (
    @(posedge clk) disable iff (!rst_n)
    bus.r_valid |-> (state_q == S_DATA)
  ) else $error("r_valid seen outside the data state");

endmodule

`default_nettype wire

//--- logic/inst_mem_slave.sv
`default_nettype none

module inst_mem_slave #(
  parameter type word_t         = fetch_pkg::mem_word_t,
  parameter int  MEM_DEPTH_LOG2 = 8,
  parameter int  READ_LATENCY   = 1
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          load_en_i,
  input  wire [fetch_pkg::ADDR_W-1:0]  load_addr_i,
  input  word_t                        load_data_i,
  axi_rd_if.slave                      bus
);

  // 8 bytes per word
  localparam int IDX_LSB = 3;
  localparam int IDX_MSB = MEM_DEPTH_LOG2 + IDX_LSB - 1;

  // latency counter, at least one bit
  localparam int CNT_W = (READ_LATENCY > 1) ? $clog2(READ_LATENCY) : 1;
  localparam logic [CNT_W-1:0] CNT_INIT = CNT_W'(READ_LATENCY - 1);

  word_t             mem [2**MEM_DEPTH_LOG2];
  logic              busy_q;
  logic [CNT_W-1:0]  cnt_q;
  word_t             data_q;
  logic [1:0]        resp_q;
  logic              ar_hs;
  logic              r_hs;
  logic              in_range;

  // accept whenever no read is pending
  assign bus.ar_ready = ~busy_q;

  // data valid once the count has run down
  assign bus.r_valid  = busy_q & (cnt_q == '0);
  assign bus.r_data   = data_q;
  assign bus.r_resp   = resp_q;

  assign ar_hs = bus.ar_valid & bus.ar_ready;
  assign r_hs  = bus.r_valid & bus.r_ready;

  // upper address bits must be clear for a hit
  assign in_range = (bus.ar_addr[fetch_pkg::ADDR_W-1:IDX_MSB+1] == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      if (ar_hs) begin
        busy_q <= 1'b1;
        cnt_q  <= CNT_INIT;
      end else if (r_hs) begin
        busy_q <= 1'b0;
      end else if (busy_q && cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // boot load, byte address in, word granular
  always_ff @(posedge clk) begin
    if (load_en_i) begin
      mem[load_addr_i[IDX_MSB:IDX_LSB]] <= load_data_i;
    end
  end

  // read at acceptance, held for the response
  // out of range gives zero data and slverr
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      data_q <= in_range ? mem[bus.ar_addr[IDX_MSB:IDX_LSB]] : '0;
      resp_q <= in_range ? fetch_pkg::RESP_OKAY : fetch_pkg::RESP_SLVERR;
    end
  end

  // beat must hold until the master takes it
  a_r_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (bus.r_valid && !bus.r_ready) |=> (bus.r_valid && $stable(bus.r_data))
  ) else $error("r_valid dropped or r_data moved while waiting for r_ready");

endmodule

`default_nettype wire

//--- logic/inst_select.sv
`default_nettype none

module inst_select (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          fetch_done_i,
  input  fetch_pkg::mem_word_t         rd_data_i,
  input  wire [1:0]                    rd_resp_i,
  input  wire [fetch_pkg::ADDR_W-1:0]  rd_addr_i,
  input  wire                          squash_i,
  output logic [fetch_pkg::INST_W-1:0] inst_o,
  output logic [fetch_pkg::ADDR_W-1:0] inst_pc_o,
  output logic                         inst_valid_o,
  output logic                         inst_fault_o
);

  logic                         squash_q;
  logic                         kill;
  logic                         fault;
  logic                         deliver;
  logic [fetch_pkg::INST_W-1:0] half;
  logic [fetch_pkg::INST_W-1:0] inst_q;
  logic [fetch_pkg::ADDR_W-1:0] pc_q;
  logic                         valid_q;
  logic                         fault_q;

  // a squash in the completion cycle still counts
  assign kill    = squash_q | squash_i;
  assign deliver = fetch_done_i & ~kill;
  assign fault   = (rd_resp_i != fetch_pkg::RESP_OKAY);

  // bit 2 picks the upper word of the beat
  assign half = rd_addr_i[2] ? rd_data_i[fetch_pkg::DATA_W-1:fetch_pkg::INST_W]
                             : rd_data_i[fetch_pkg::INST_W-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      squash_q <= 1'b0;
      valid_q  <= 1'b0;
      fault_q  <= 1'b0;
      inst_q   <= fetch_pkg::NOP_INST;
    end else begin
      // flag lives until the squashed beat returns
      if (fetch_done_i) begin
        squash_q <= 1'b0;
      end else if (squash_i) begin
        squash_q <= 1'b1;
      end
      valid_q <= deliver;
      fault_q <= deliver & fault;
      // nop for idle, squashed or faulting fetches
      inst_q  <= (deliver && !fault) ? half : fetch_pkg::NOP_INST;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_done_i) begin
      pc_q <= rd_addr_i;
    end
  end

  assign inst_o       = inst_q;
  assign inst_pc_o    = pc_q;
  assign inst_valid_o = valid_q;
  assign inst_fault_o = fault_q;

endmodule

`default_nettype wire

//--- logic/fetch_top.sv
`default_nettype none

module fetch_top #(
  parameter logic [fetch_pkg::ADDR_W-1:0] RESET_PC       = '0,
  parameter int                           MEM_DEPTH_LOG2 = 8,
  parameter int                           READ_LATENCY   = 1
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          redirect_i,
  input  wire [fetch_pkg::ADDR_W-1:0]  redirect_pc_i,
  input  wire                          stall_i,
  input  wire                          load_en_i,
  input  wire [fetch_pkg::ADDR_W-1:0]  load_addr_i,
  input  fetch_pkg::mem_word_t         load_data_i,
  output logic [fetch_pkg::INST_W-1:0] inst_o,
  output logic [fetch_pkg::ADDR_W-1:0] inst_pc_o,
  output logic                         inst_valid_o,
  output logic                         inst_fault_o
);

  // pc side
  logic                         fetch_req;
  logic [fetch_pkg::ADDR_W-1:0] fetch_addr;
  logic                         fetch_done;
  logic                         squash;

  // completed beat toward select stage
  fetch_pkg::mem_word_t         rd_data;
  logic [1:0]                   rd_resp;
  logic [fetch_pkg::ADDR_W-1:0] rd_addr;

  axi_rd_if rd_bus ();

  pc_gen #(
    .RESET_PC (RESET_PC)
  ) i_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .fetch_done_i  (fetch_done),
    .fetch_req_o   (fetch_req),
    .fetch_addr_o  (fetch_addr),
    .squash_o      (squash)
  );

  fetch_axi_master i_master (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_req_i  (fetch_req),
    .fetch_addr_i (fetch_addr),
    .fetch_done_o (fetch_done),
    .rd_data_o    (rd_data),
    .rd_resp_o    (rd_resp),
    .rd_addr_o    (rd_addr),
    .bus          (rd_bus.master)
  );

  // memory word type fixed to the 64-bit beat
  inst_mem_slave #(
    .word_t         (fetch_pkg::mem_word_t),
    .MEM_DEPTH_LOG2 (MEM_DEPTH_LOG2),
    .READ_LATENCY   (READ_LATENCY)
  ) i_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_en_i   (load_en_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i),
    .bus         (rd_bus.slave)
  );

  inst_select i_select (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_done_i (fetch_done),
    .rd_data_i    (rd_data),
    .rd_resp_i    (rd_resp),
    .rd_addr_i    (rd_addr),
    .squash_i     (squash),
    .inst_o       (inst_o),
    .inst_pc_o    (inst_pc_o),
    .inst_valid_o (inst_valid_o),
    .inst_fault_o (inst_fault_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_fetch.sv
`default_nettype none

module tb_fetch;

  localparam logic [fetch_pkg::ADDR_W-1:0] RESET_PC = 64'h0;
  localparam int MEM_DEPTH_LOG2 = 8;
  localparam int READ_LATENCY   = 3;
  localparam int MEM_WORDS      = 2 ** MEM_DEPTH_LOG2;
  // highest byte address bit that still selects a word
  localparam int IDX_MSB        = MEM_DEPTH_LOG2 + 2;
  localparam int SEED           = 82318;
  localparam int WAIT_LIMIT     = 60;

  logic                         clk = 1'b0;
  logic                         rst_n;
  logic                         redirect_i;
  logic [fetch_pkg::ADDR_W-1:0] redirect_pc_i;
  logic                         stall_i;
  logic                         load_en_i;
  logic [fetch_pkg::ADDR_W-1:0] load_addr_i;
  fetch_pkg::mem_word_t         load_data_i;
  logic [fetch_pkg::INST_W-1:0] inst_o;
  logic [fetch_pkg::ADDR_W-1:0] inst_pc_o;
  logic                         inst_valid_o;
  logic                         inst_fault_o;

  // local copy of what the boot port wrote
  fetch_pkg::mem_word_t         mirror [MEM_WORDS];
  fetch_pkg::mem_word_t         word;

  // redirect hand-over from stimulus to tracker
  int                           redir_seq = 0;
  logic [fetch_pkg::ADDR_W-1:0] redir_target = '0;

  // tracker state of the comparison process
  int                           seen_seq = 0;
  int                           deliv_count = 0;
  logic [fetch_pkg::ADDR_W-1:0] exp_pc = RESET_PC;
  logic [fetch_pkg::INST_W:0]   expected;
  int                           stall_start;

  always #4 clk = ~clk;

  fetch_top #(
    .RESET_PC       (RESET_PC),
    .MEM_DEPTH_LOG2 (MEM_DEPTH_LOG2),
    .READ_LATENCY   (READ_LATENCY)
  ) i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .load_en_i     (load_en_i),
    .load_addr_i   (load_addr_i),
    .load_data_i   (load_data_i),
    .inst_o        (inst_o),
    .inst_pc_o     (inst_pc_o),
    .inst_valid_o  (inst_valid_o),
    .inst_fault_o  (inst_fault_o)
  );

  // expected {fault, instruction} for one fetch address
  function automatic logic [fetch_pkg::INST_W:0] ref_fetch(
    input logic [fetch_pkg::ADDR_W-1:0] addr
  );
    fetch_pkg::mem_word_t w;
    // anything above the memory faults
    if (addr[fetch_pkg::ADDR_W-1:IDX_MSB+1] != '0) begin
      return {1'b1, fetch_pkg::NOP_INST};
    end
    w = mirror[addr[IDX_MSB:3]];
    // bit 2 picks the upper instruction of the word
    return {1'b0, addr[2] ? w[63:32] : w[31:0]};
  endfunction

  task automatic check_equal(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL at time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // one delivery sampled at the falling edge
  task automatic wait_delivery(input string what);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      seen = inst_valid_o;
      cycles++;
    end
    if (!seen) begin
      $display("timeout: no inst_valid_o within %0d cycles during %s", WAIT_LIMIT, what);
      $display("CHECKS FAILED");
      $fatal(1, "wait for instruction delivery timed out");
    end
  endtask

  // one-cycle redirect pulse and tracker update on the same edge
  task automatic drive_redirect(input logic [fetch_pkg::ADDR_W-1:0] target);
    @(posedge clk);
    redirect_i    <= 1'b1;
    redirect_pc_i <= target;
    redir_target  = target;
    redir_seq++;
    @(posedge clk);
    redirect_i    <= 1'b0;
  endtask

  // comparison process
  always @(negedge clk) begin
    if (rst_n) begin
      // a redirect discards whatever was in flight
      if (redir_seq != seen_seq) begin
        exp_pc   = redir_target;
        seen_seq = redir_seq;
      end
      if (inst_valid_o) begin
        expected = ref_fetch(exp_pc);
        check_equal("inst_pc_o", inst_pc_o, exp_pc);
        check_equal("inst_o", 64'(inst_o), 64'(expected[fetch_pkg::INST_W-1:0]));
        check_equal("inst_fault_o", 64'(inst_fault_o), 64'(expected[fetch_pkg::INST_W]));
        exp_pc = exp_pc + 64'd4;
        deliv_count++;
      end else begin
        check_equal("inst_o while idle", 64'(inst_o), 64'(fetch_pkg::NOP_INST));
      end
    end
  end

  initial begin
    void'($urandom(SEED));
    rst_n         <= 1'b0;
    redirect_i    <= 1'b0;
    redirect_pc_i <= '0;
    // fetch held off with stall until the boot load is done
    stall_i       <= 1'b1;
    load_en_i     <= 1'b0;
    load_addr_i   <= '0;
    load_data_i   <= '0;

    // boot load while reset drops after 16 edges
    for (int i = 0; i < MEM_WORDS; i++) begin
      @(posedge clk);
      word        = {$urandom, $urandom};
      mirror[i]   = word;
      load_en_i   <= 1'b1;
      load_addr_i <= 64'(i * 8);
      load_data_i <= word;
      if (i == 15) begin
        rst_n <= 1'b1;
      end
    end
    @(posedge clk);
    load_en_i <= 1'b0;

    // nothing delivered yet
    @(negedge clk);
    check_equal("inst_valid_o before first fetch", 64'(inst_valid_o), 64'd0);
    check_equal("deliveries before first fetch", 64'(deliv_count), 64'd0);
    @(posedge clk);
    stall_i <= 1'b0;

    // straight-line fetch from reset pc
    repeat (40) wait_delivery("sequential fetch");

    // redirect with the bus drained by a stall
    @(posedge clk);
    stall_i <= 1'b1;
    wait_delivery("fetch in flight before idle redirect");
    drive_redirect(64'h200);
    stall_i <= 1'b0;
    wait_delivery("fetch after redirect");
    check_equal("pc after redirect", inst_pc_o, 64'h200);
    repeat (3) wait_delivery("fetch following redirect target");

    // redirect with the next fetch on the bus
    @(posedge clk);
    drive_redirect(64'h3a4);
    wait_delivery("fetch after in-flight redirect");
    check_equal("pc after in-flight redirect", inst_pc_o, 64'h3a4);
    repeat (4) wait_delivery("fetch following in-flight redirect");

    // stall and release
    @(posedge clk);
    stall_i     <= 1'b1;
    stall_start = deliv_count;
    repeat (30) @(posedge clk);
    check_equal("deliveries while stalled at most one",
                64'((deliv_count - stall_start) <= 1), 64'd1);
    stall_i <= 1'b0;
    repeat (4) wait_delivery("fetch after stall release");

    // out of range target and back into memory
    drive_redirect(64'h1000);
    wait_delivery("out of range fetch");
    check_equal("fault on out of range fetch", 64'(inst_fault_o), 64'd1);
    drive_redirect(64'h80);
    wait_delivery("fetch after recovery redirect");
    check_equal("fault cleared after recovery", 64'(inst_fault_o), 64'd0);
    repeat (4) wait_delivery("fetch after recovery");

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
logic/fetch_pkg.sv
logic/axi_rd_if.sv
logic/pc_gen.sv
logic/fetch_axi_master.sv
logic/inst_mem_slave.sv
logic/inst_select.sv
logic/fetch_top.sv
testbench/tb_fetch.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_fetch \
  -f project.f -o tb_fetch_sim \
  && ./obj_dir/tb_fetch_sim > sim.log 2>&1 \
  || echo "build or simulation returned an error"

cat sim.log 2>/dev/null

grep -q "ALL CHECKS PASSED" sim.log && echo "result: pass" && exit 0 \
  || { echo "result: fail"; exit 1; }
